//--- tb/am_lock_stimulus.txt
// first word: number of cycle lines (hex), then per line
// we addr wdata block_lock valid block | exp am_lock restore_am start_of_lane mask rdata
52
// reset state, status read, then a lane 2 marker and a lane 1 marker at expiry
0 3 00 1 1 10123456789abcdef 0 0 0 f 00
0 0 00 1 1 10123456789abcdef 0 0 0 f 01
0 0 00 1 1 2594be83ca6b417c3 0 0 0 f 01
0 0 00 1 1 10123456789abcdef 0 0 0 f 01
0 0 00 1 1 10123456789abcdef 0 1 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 29d718e5a628e7171 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 1 4 01
// lock acquisition on lane 2 with lock_thr 1
0 0 00 1 1 2594be83ca6b417c3 0 0 0 f 01
0 0 00 1 1 10123456789abcdef 0 0 0 f 01
0 0 00 1 1 10123456789abcdef 0 1 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 2594be83ca6b417c3 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 1 4 01
0 0 00 1 1 10123456789abcdef 0 1 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 2594be83ca6b417c3 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 1 4 01
// locked, unlock_thr set to 1, marker kept, then three idle cycles
1 2 01 1 1 10123456789abcdef 1 1 0 4 03
0 2 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 2594be83ca6b417c3 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 1 4 01
0 0 00 1 0 10123456789abcdef 1 1 0 4 01
0 0 00 1 0 10123456789abcdef 1 0 0 4 01
0 0 00 1 0 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
// two expiries without a marker drop the lock
0 0 00 1 1 10123456789abcdef 1 0 1 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
0 3 00 1 1 10123456789abcdef 1 0 1 4 01
0 3 00 1 1 10123456789abcdef 0 0 0 f 00
0 3 00 1 1 10123456789abcdef 0 0 0 f 02
1 3 00 1 1 10123456789abcdef 0 0 0 f 02
0 3 00 1 1 10123456789abcdef 0 0 0 f 00
// lock_thr 0, so one confirming marker locks
1 1 00 1 1 10123456789abcdef 0 0 0 f 01
0 1 00 1 1 2594be83ca6b417c3 0 0 0 f 00
0 0 00 1 1 10123456789abcdef 0 0 0 f 01
0 0 00 1 1 10123456789abcdef 0 1 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 0 4 01
0 0 00 1 1 2594be83ca6b417c3 0 0 0 4 01
0 0 00 1 1 10123456789abcdef 0 0 1 4 01
0 0 00 1 1 10123456789abcdef 1 1 0 4 01
0 0 00 1 1 10123456789abcdef 1 0 0 4 01
// block lock lost while locked
0 3 00 0 1 10123456789abcdef 1 0 0 4 01
0 3 00 0 1 10123456789abcdef 0 0 0 f 00
0 3 00 0 1 10123456789abcdef 0 0 0 f 02
0 0 00 0 1 10123456789abcdef 0 0 0 f 01
0 0 00 0 1 10123456789abcdef 0 0 0 f 01
0 0 00 0 1 10123456789abcdef 0 0 0 f 01
0 0 00 0 1 10123456789abcdef 0 0 0 f 01
0 0 00 0 1 10123456789abcdef 0 0 0 f 01

//--- vlog.f
hdl/am_lock_pkg.sv
hdl/am_comparator.sv
hdl/am_lock_fsm.sv
hdl/am_lock_cfg_regs.sv
hdl/am_lock_top.sv
tb/am_lock_properties.sv
tb/tb_am_lock.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the am lock testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

{ verilator --binary --assert --timescale 1ns/1ns --top-module tb_am_lock \
	-f vlog.f -o tb_am_lock && ./obj_dir/tb_am_lock; } > "$LOG" 2>&1 \
	|| echo "build or simulation returned an error status" >> "$LOG"

cat "$LOG"

grep -q "RESULT: FAIL" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" "$LOG" || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

//--- tb/tb_am_lock.sv
`timescale 1ns/1ns

module tb_am_lock;

	import am_lock_pkg::*;

	localparam int N_ALIGNERS   = 4;
	localparam int N_BLOCKS     = 8;
	localparam int CLOCK_PERIOD = 100;
	localparam int DRIVE_DELAY  = 10;   // after the rising edge
	localparam int SAMPLE_LEAD  = 10;   // before the next rising edge
	localparam int RESET_CYCLES = 5;
	localparam int N_COLS       = 11;   // tokens per stimulus line
	localparam int MAX_LINES    = 256;
	localparam int MAX_WORDS    = 1 + N_COLS * MAX_LINES;

	typedef struct packed {
		logic       cfg_we;
		logic [1:0] cfg_addr;
		logic [7:0] cfg_wdata;
		logic       block_lock;
		logic       valid;
		t_block     block;
	} t_drive;

	typedef struct packed {
		logic                  am_lock;
		logic                  restore_am;
		logic                  start_of_lane;
		logic [N_ALIGNERS-1:0] match_mask;
		logic [7:0]            cfg_rdata;
	} t_expect;

	logic                    clock;
	logic                    rst_n;
	t_drive                  drv;
	t_expect                 exp_v;
	t_am_status              status;
	logic [N_ALIGNERS-1:0]   match_mask;
	logic [7:0]              cfg_rdata;

	logic [67:0]             stim_mem [MAX_WORDS];   // word 0 is the line count
	int                      n_lines;
	int                      cur_line;

	am_lock_top #(
		.N_ALIGNERS (N_ALIGNERS),
		.N_BLOCKS   (N_BLOCKS)
	) uut (
		.i_clock      (clock),
		.i_rst_n      (rst_n),
		.i_block_lock (drv.block_lock),
		.i_valid      (drv.valid),
		.i_block      (drv.block),
		.i_cfg_we     (drv.cfg_we),
		.i_cfg_addr   (drv.cfg_addr),
		.i_cfg_wdata  (drv.cfg_wdata),
		.o_status     (status),
		.o_match_mask (match_mask),
		.o_cfg_rdata  (cfg_rdata)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic check_value(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR %s at stimulus line %0d: got 0x%h, expected 0x%h",
				name, cur_line, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// one line of the file into drive and expect fields
	task automatic read_line(input int line, output t_drive d, output t_expect e);
		int base;
		base            = 1 + line * N_COLS;
		d.cfg_we        = stim_mem[base][0];
		d.cfg_addr      = stim_mem[base + 1][1:0];
		d.cfg_wdata     = stim_mem[base + 2][7:0];
		d.block_lock    = stim_mem[base + 3][0];
		d.valid         = stim_mem[base + 4][0];
		d.block         = stim_mem[base + 5][65:0];
		e.am_lock       = stim_mem[base + 6][0];
		e.restore_am    = stim_mem[base + 7][0];
		e.start_of_lane = stim_mem[base + 8][0];
		e.match_mask    = stim_mem[base + 9][N_ALIGNERS-1:0];
		e.cfg_rdata     = stim_mem[base + 10][7:0];
	endtask

	initial
	begin
		rst_n    = 1'b0;
		drv      = '0;
		exp_v    = '0;
		cur_line = 0;
		$readmemh("tb/am_lock_stimulus.txt", stim_mem);
		n_lines = int'(stim_mem[0][31:0]);
		if (n_lines < 1 || n_lines > MAX_LINES)
		begin
			$display("stimulus file is missing or gives no usable line count");
			$display("RESULT: FAIL");
			$fatal(1, "bad stimulus file");
		end
		repeat (RESET_CYCLES) @(posedge clock);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		for (int line = 0; line < n_lines; line++)
		begin
			cur_line = line;
			read_line(line, drv, exp_v);
			#(CLOCK_PERIOD - DRIVE_DELAY - SAMPLE_LEAD);   // outputs settled here
			check_value("am_lock", 8'(status.am_lock), 8'(exp_v.am_lock));
			check_value("restore_am", 8'(status.restore_am), 8'(exp_v.restore_am));
			check_value("start_of_lane", 8'(status.start_of_lane), 8'(exp_v.start_of_lane));
			// search and lane timers restart on the same events here
			check_value("search_timer_done", 8'(status.search_timer_done),
				8'(exp_v.start_of_lane));
			check_value("resync_by_am_start", 8'(status.resync_by_am_start), 8'h00);
			check_value("match_mask", 8'(match_mask), 8'(exp_v.match_mask));
			check_value("cfg_rdata", cfg_rdata, exp_v.cfg_rdata);
			@(posedge clock);
			#(DRIVE_DELAY);
		end
		$display("RESULT: PASS");
		$finish;
	end

	// run length follows the stimulus file
	initial
	begin
		#1;
		#((n_lines + RESET_CYCLES + 20) * CLOCK_PERIOD);
		$display("timeout: the stimulus did not finish in the expected time");
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- tb/am_lock_properties.sv
`timescale 1ns/1ns

module am_lock_properties
#(
	parameter int         N_ALIGNERS  = 20,
	parameter logic [3:0] ST_WAIT_1ST = 4'b0100,
	parameter logic [3:0] ST_WAIT_2ND = 4'b0010
)
(
	input logic                    i_clock,
	input logic                    i_rst_n,
	input logic [3:0]              i_state,
	input logic                    i_am_lock,
	input logic                    i_restore_am,
	input logic [N_ALIGNERS-1:0]   i_match_mask
);

	// restore_am lasts one clock at most
	restore_single_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_restore_am |=> !i_restore_am)
		else $error("restore_am was high on two consecutive clocks");

	// lock is only granted while confirming the second marker
	lock_only_from_wait_2nd: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$rose(i_am_lock) |-> ($past(i_state) == ST_WAIT_2ND))
		else $error("am_lock rose while the state was not WAIT_2ND");

	mask_open_in_wait_1st: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_state == ST_WAIT_1ST) |-> (&i_match_mask))   // every lane may start a search
		else $error("match mask was not all ones in WAIT_1ST");

endmodule

bind am_lock_fsm am_lock_properties #(
	.N_ALIGNERS  (N_ALIGNERS),
	.ST_WAIT_1ST (WAIT_1ST),
	.ST_WAIT_2ND (WAIT_2ND)
) u_properties (
	.i_clock      (i_clock),
	.i_rst_n      (i_rst_n),
	.i_state      (state),
	.i_am_lock    (am_lock),
	.i_restore_am (restore_am),
	.i_match_mask (match_mask)
);

//--- hdl/am_lock_top.sv
`timescale 1ns/1ns

module am_lock_top
#(
	parameter int N_ALIGNERS = 20,
	parameter int N_BLOCKS   = 16383
)
(
	input  logic                      i_clock,
	input  logic                      i_rst_n,
	input  logic                      i_block_lock,
	input  logic                      i_valid,
	input  am_lock_pkg::t_block       i_block,
	input  logic                      i_cfg_we,
	input  logic [1:0]                i_cfg_addr,
	input  logic [7:0]                i_cfg_wdata,

	output am_lock_pkg::t_am_status   o_status,
	output logic [N_ALIGNERS-1:0]     o_match_mask,
	output logic [7:0]                o_cfg_rdata
);

	import am_lock_pkg::*;

	logic                   cmp_valid;
	logic                   cmp_am_valid;
	logic [N_ALIGNERS-1:0]  match_vector;
	t_am_cfg                cfg;

	// one cycle decode stage
	am_comparator #(
		.N_ALIGNERS (N_ALIGNERS)
	) u_comparator (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_valid        (i_valid),
		.i_block        (i_block),
		.i_match_mask   (o_match_mask),
		.o_valid        (cmp_valid),
		.o_match_vector (match_vector),
		.o_am_valid     (cmp_am_valid)
	);

	am_lock_fsm #(
		.N_ALIGNERS (N_ALIGNERS),
		.N_BLOCKS   (N_BLOCKS)
	) u_fsm (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_block_lock   (i_block_lock),   // not delayed, lock drops on next edge
		.i_valid        (cmp_valid),
		.i_am_valid     (cmp_am_valid),
		.i_match_vector (match_vector),
		.i_cfg          (cfg),
		.o_match_mask   (o_match_mask),
		.o_status       (o_status)
	);

	am_lock_cfg_regs u_cfg_regs (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_cfg_we    (i_cfg_we),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.i_am_lock   (o_status.am_lock),
		.o_cfg       (cfg),
		.o_cfg_rdata (o_cfg_rdata)
	);

endmodule

//--- hdl/am_lock_cfg_regs.sv
`timescale 1ns/1ns

module am_lock_cfg_regs
(
	input  logic                   i_clock,
	input  logic                   i_rst_n,
	input  logic                   i_cfg_we,
	input  logic [1:0]             i_cfg_addr,
	input  logic [7:0]             i_cfg_wdata,
	input  logic                   i_am_lock,

	output am_lock_pkg::t_am_cfg   o_cfg,
	output logic [7:0]             o_cfg_rdata
);

	import am_lock_pkg::*;

	localparam logic [1:0] ADDR_ENABLE = 2'd0;
	localparam logic [1:0] ADDR_LOCK   = 2'd1;
	localparam logic [1:0] ADDR_UNLOCK = 2'd2;
	localparam logic [1:0] ADDR_STATUS = 2'd3;

	t_am_cfg cfg;
	logic    am_lock_q;   // previous lock, for edge detect
	logic    lock_lost;

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			cfg <= '{enable: 1'b1, lock_thr: CFG_THR_W'(1), unlock_thr: CFG_THR_W'(3)};
		else if (i_cfg_we)
		begin
			case (i_cfg_addr)
				ADDR_ENABLE: cfg.enable     <= i_cfg_wdata[0];
				ADDR_LOCK:   cfg.lock_thr   <= i_cfg_wdata[CFG_THR_W-1:0];
				ADDR_UNLOCK: cfg.unlock_thr <= i_cfg_wdata[CFG_THR_W-1:0];
				default:     ;   // status handled below
			endcase
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			am_lock_q <= 1'b0;
			lock_lost <= 1'b0;
		end
		else
		begin
			am_lock_q <= i_am_lock;
			if (am_lock_q && !i_am_lock)   // a new loss beats the clear
				lock_lost <= 1'b1;
			else if (i_cfg_we && i_cfg_addr == ADDR_STATUS)
				lock_lost <= 1'b0;
		end
	end

	always_comb
	begin
		case (i_cfg_addr)
			ADDR_ENABLE: o_cfg_rdata = {7'b0, cfg.enable};
			ADDR_LOCK:   o_cfg_rdata = 8'(cfg.lock_thr);
			ADDR_UNLOCK: o_cfg_rdata = 8'(cfg.unlock_thr);
			default:     o_cfg_rdata = {6'b0, lock_lost, i_am_lock};
		endcase
	end

	assign o_cfg = cfg;

endmodule

//--- hdl/am_lock_fsm.sv
`timescale 1ns/1ns

module am_lock_fsm
#(
	parameter int N_ALIGNERS = 20,
	parameter int N_BLOCKS   = 16383
)
(
	input  logic                      i_clock,
	input  logic                      i_rst_n,
	input  logic                      i_block_lock,
	input  logic                      i_valid,
	input  logic                      i_am_valid,
	input  logic [N_ALIGNERS-1:0]     i_match_vector,
	input  am_lock_pkg::t_am_cfg      i_cfg,

	output logic [N_ALIGNERS-1:0]     o_match_mask,
	output am_lock_pkg::t_am_status   o_status
);

	import am_lock_pkg::*;

	localparam logic [3:0] INIT     = 4'b1000;
	localparam logic [3:0] WAIT_1ST = 4'b0100;
	localparam logic [3:0] WAIT_2ND = 4'b0010;
	localparam logic [3:0] LOCKED   = 4'b0001;

	localparam int NB_COUNTER = $clog2(N_BLOCKS + 1);
	localparam logic [NB_COUNTER-1:0] TIMER_START = NB_COUNTER'(1);
	localparam logic [NB_COUNTER-1:0] TIMER_END   = NB_COUNTER'(N_BLOCKS);

	logic [3:0]             state, next_state;
	logic [N_ALIGNERS-1:0]  match_mask, match_mask_next;
	logic                   am_lock, am_lock_next;
	logic                   restore_am, restore_am_next;
	logic                   resync;
	logic                   reset_timer_search, reset_timer_lock;
	logic [NB_COUNTER-1:0]  timer_search, timer_lock;
	logic [CFG_THR_W-1:0]   valid_count, invalid_count;
	logic                   advance;
	logic                   timer_search_done, start_of_lane;
	logic                   valid_count_full, invalid_count_full;

	assign advance            = i_valid && i_cfg.enable;
	assign timer_search_done  = (timer_search == TIMER_END);
	assign start_of_lane      = (timer_lock == TIMER_END);
	assign valid_count_full   = (valid_count == i_cfg.lock_thr);
	assign invalid_count_full = (invalid_count == i_cfg.unlock_thr);

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state      <= INIT;
			am_lock    <= 1'b0;
			match_mask <= '1;
		end
		else if (!i_block_lock)   // block lock gone, start over
		begin
			state      <= INIT;
			am_lock    <= 1'b0;
			match_mask <= '1;
		end
		else if (advance)
		begin
			state      <= next_state;
			am_lock    <= am_lock_next;
			match_mask <= match_mask_next;
		end
	end

	always_comb
	begin
		next_state         = state;
		am_lock_next       = am_lock;
		match_mask_next    = match_mask;
		restore_am_next    = 1'b0;
		reset_timer_search = 1'b0;
		reset_timer_lock   = 1'b0;
		case (state)
			INIT:
			begin
				am_lock_next    = 1'b0;
				match_mask_next = '1;
				next_state      = WAIT_1ST;
			end
			WAIT_1ST:
			begin
				if (i_am_valid)
				begin
					match_mask_next    = i_match_vector;   // follow this lane only
					restore_am_next    = 1'b1;
					reset_timer_search = 1'b1;
					reset_timer_lock   = 1'b1;
					next_state         = WAIT_2ND;
				end
			end
			WAIT_2ND:
			begin
				if (timer_search_done && i_am_valid)
				begin
					restore_am_next = 1'b1;
					if (valid_count_full)
					begin
						am_lock_next       = 1'b1;
						reset_timer_search = 1'b1;
						reset_timer_lock   = 1'b1;
						next_state         = LOCKED;
					end
				end
				else if (timer_search_done)
				begin
					match_mask_next = '1;   // second marker missing
					next_state      = WAIT_1ST;
				end
			end
			LOCKED:
			begin
				if (timer_search_done && i_am_valid)
				begin
					restore_am_next = 1'b1;
				end
				else if (timer_search_done && invalid_count_full)
				begin
					am_lock_next    = 1'b0;
					match_mask_next = '1;
					next_state      = WAIT_1ST;
				end
			end
			default:
			begin
				next_state = INIT;
			end
		endcase
	end

	// pulses last one clock even when valid drops
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			restore_am <= 1'b0;
			resync     <= 1'b0;
		end
		else
		begin
			restore_am <= i_block_lock && advance && restore_am_next;
			resync     <= i_block_lock && advance && am_lock_next && !am_lock
				&& (timer_lock != timer_search);
		end
	end

	// consecutive good markers, only meaningful while confirming
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			valid_count <= '0;
		else if (!i_block_lock)
			valid_count <= '0;
		else if (advance && state != WAIT_2ND)
			valid_count <= '0;
		else if (advance && timer_search_done)
			valid_count <= i_am_valid ? valid_count + 1'b1 : '0;
	end

	// missed markers since lock
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			invalid_count <= '0;
		else if (!i_block_lock)
			invalid_count <= '0;
		else if (advance && state != LOCKED)
			invalid_count <= '0;
		else if (advance && timer_search_done && !i_am_valid)
			invalid_count <= invalid_count + 1'b1;
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			timer_search <= TIMER_START;
			timer_lock   <= TIMER_START;
		end
		else if (!i_block_lock)
		begin
			timer_search <= TIMER_START;
			timer_lock   <= TIMER_START;
		end
		else if (advance)
		begin
			timer_search <= (reset_timer_search || timer_search_done) ?
				TIMER_START : timer_search + 1'b1;
			timer_lock   <= (reset_timer_lock || start_of_lane) ?
				TIMER_START : timer_lock + 1'b1;
		end
	end

	assign o_match_mask                = match_mask;
	assign o_status.am_lock            = am_lock;
	assign o_status.resync_by_am_start = resync;
	assign o_status.start_of_lane      = start_of_lane;
	assign o_status.restore_am         = restore_am;
	assign o_status.search_timer_done  = timer_search_done;

endmodule

//--- hdl/am_comparator.sv
`timescale 1ns/1ns

module am_comparator
#(
	parameter int N_ALIGNERS = 20
)
(
	input  logic                    i_clock,
	input  logic                    i_rst_n,
	input  logic                    i_valid,
	input  am_lock_pkg::t_block     i_block,
	input  logic [N_ALIGNERS-1:0]   i_match_mask,

	output logic                    o_valid,
	output logic [N_ALIGNERS-1:0]   o_match_vector,
	output logic                    o_am_valid
);

	import am_lock_pkg::*;

	t_am_fields             am;
	logic                   hdr_ok;
	logic [23:0]            m_low;    // M0..M2
	logic [23:0]            m_high;   // M4..M6
	logic [N_ALIGNERS-1:0]  match_comb;

	assign am     = i_block.am;
	assign hdr_ok = (am.sync_hdr == 2'b10);   // control block header
	assign m_low  = {am.m0, am.m1, am.m2};
	assign m_high = {am.m4, am.m5, am.m6};

	// all lanes compared in parallel
	always_comb
	begin
		for (int i = 0; i < N_ALIGNERS; i++)
		begin
			match_comb[i] = hdr_ok
				&& (m_low == AM_PATTERNS[i])
				&& (m_high == ~AM_PATTERNS[i]);
		end
	end

	// strobe and masked marker flag
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_valid    <= 1'b0;
			o_am_valid <= 1'b0;
		end
		else
		begin
			o_valid    <= i_valid;
			o_am_valid <= i_valid && |(match_comb & i_match_mask);
		end
	end

	// lane hits travel alongside the flag
	always_ff @(posedge i_clock)
	begin
		o_match_vector <= match_comb;
	end

endmodule

//--- hdl/am_lock_pkg.sv
package am_lock_pkg;

	localparam int MAX_ALIGNERS = 20;
	localparam int CFG_THR_W    = 5;   // lock and unlock threshold width

	// M0,M1,M2 of each pcs lane marker, M4..M6 are the bitwise inverse
	localparam logic [23:0] AM_PATTERNS [MAX_ALIGNERS] = '{
		24'hC16821,
		24'h9D718E,
		24'h594BE8,
		24'h4D957B,
		24'hF50709,
		24'hDD14C2,
		24'h9A4A26,
		24'h7B4566,
		24'hA02476,
		24'h68C9FB,
		24'hFD6C99,
		24'hB99155,
		24'h5CB9B2,
		24'h1AF8BD,
		24'h83C7CA,
		24'h3536CD,
		24'hC4314C,
		24'hADD6B7,
		24'h5F662A,
		24'hC0F0E5   // lane 19
	};

	typedef struct packed {
		logic [1:0] sync_hdr;
		logic [7:0] m0;
		logic [7:0] m1;
		logic [7:0] m2;
		logic [7:0] bip3;
		logic [7:0] m4;
		logic [7:0] m5;
		logic [7:0] m6;
		logic [7:0] bip7;
	} t_am_fields;

	typedef struct packed {
		logic [1:0]  sync_hdr;
		logic [63:0] payload;
	} t_data_fields;

	// one 66-bit block, seen as a marker or as plain data
	typedef union packed {
		t_am_fields   am;
		t_data_fields data;
	} t_block;

	typedef struct packed {
		logic                 enable;
		logic [CFG_THR_W-1:0] lock_thr;
		logic [CFG_THR_W-1:0] unlock_thr;
	} t_am_cfg;

	typedef struct packed {
		logic am_lock;
		logic resync_by_am_start;
		logic start_of_lane;
		logic restore_am;
		logic search_timer_done;
	} t_am_status;

endpackage
